// ==== filelist.f ====
+incdir+hdl
+incdir+verification
hdl/lc4_isa_pkg.sv
hdl/lc4_pipe_pkg.sv
hdl/lc4_decoder.sv
hdl/lc4_regfile.sv
hdl/lc4_alu.sv
hdl/lc4_hazard_unit.sv
hdl/lc4_bypass_unit.sv
hdl/lc4_processor.sv
verification/tb_lc4_processor.sv

// ==== hdl/lc4_alu.sv ====
//**************************************************
// x stage datapath: result, address, branch target
//**************************************************
`timescale 1ns/1ns
`default_nettype none
`include "lc4_config.svh"

module lc4_alu (
    input  wire lc4_isa_pkg::ctrl_t   i_ctrl,
    input  wire [`LC4_WORD_W-1:0]     i_pc,
    input  wire [`LC4_WORD_W-1:0]     i_rs_data,
    input  wire [`LC4_WORD_W-1:0]     i_rt_data,
    input  wire [2:0]                 i_nzp,
    output logic [`LC4_WORD_W-1:0]    o_result,
    output logic [2:0]                o_nzp,
    output logic                      o_branch_taken
);

    logic [`LC4_WORD_W-1:0] op_a;
    logic [`LC4_WORD_W-1:0] op_b;

    // branches add to pc + 1, memory ops add to the base
    assign op_a = i_ctrl.is_branch ? i_pc + 1'b1 : i_rs_data;
    assign op_b = (i_ctrl.is_branch || i_ctrl.is_load || i_ctrl.is_store) ?
                  i_ctrl.imm : i_rt_data;

    always_comb begin
        case (i_ctrl.alu_op)
            lc4_isa_pkg::alu_sub: o_result = op_a - op_b;
            lc4_isa_pkg::alu_and: o_result = op_a & op_b;
            // const loads the sign-extended immediate
            lc4_isa_pkg::alu_pass: o_result = i_ctrl.imm;
            default: o_result = op_a + op_b;
        endcase
    end

    assign o_nzp = lc4_isa_pkg::nzp_of(o_result);

    // i_nzp is the architectural register, already updated by older insns
    assign o_branch_taken = i_ctrl.is_branch && |(i_ctrl.br_mask & i_nzp);

endmodule

`default_nettype wire

// ==== hdl/lc4_bypass_unit.sv ====
//**************************************************
// m/w to x operand bypass and w to m store data
// a load in m is never a source, the stall covers it
//**************************************************
`timescale 1ns/1ns
`default_nettype none
`include "lc4_config.svh"

module lc4_bypass_unit (
    input  wire lc4_isa_pkg::ctrl_t  i_x_ctrl,
    input  wire lc4_isa_pkg::ctrl_t  i_m_ctrl,
    input  wire lc4_isa_pkg::ctrl_t  i_w_ctrl,
    input  wire [`LC4_WORD_W-1:0]    i_x_rs_data,
    input  wire [`LC4_WORD_W-1:0]    i_x_rt_data,
    input  wire [`LC4_WORD_W-1:0]    i_m_result,
    input  wire [`LC4_WORD_W-1:0]    i_m_rt_data,
    input  wire [`LC4_WORD_W-1:0]    i_w_data,
    output logic [`LC4_WORD_W-1:0]   o_rs_op,
    output logic [`LC4_WORD_W-1:0]   o_rt_op,
    output logic [`LC4_WORD_W-1:0]   o_store_data
);

    logic m_rs, w_rs, m_rt, w_rt, w_store;

    // youngest producer first
    assign m_rs = i_x_ctrl.rs_re && i_m_ctrl.rd_we && i_m_ctrl.rd_sel == i_x_ctrl.rs_sel;
    assign w_rs = i_x_ctrl.rs_re && i_w_ctrl.rd_we && i_w_ctrl.rd_sel == i_x_ctrl.rs_sel;
    assign m_rt = i_x_ctrl.rt_re && i_m_ctrl.rd_we && i_m_ctrl.rd_sel == i_x_ctrl.rt_sel;
    assign w_rt = i_x_ctrl.rt_re && i_w_ctrl.rd_we && i_w_ctrl.rd_sel == i_x_ctrl.rt_sel;

    assign o_rs_op = m_rs ? i_m_result : (w_rs ? i_w_data : i_x_rs_data);
    assign o_rt_op = m_rt ? i_m_result : (w_rt ? i_w_data : i_x_rt_data);

    // ldr then str of the same register resolves here
    assign w_store = i_m_ctrl.is_store && i_w_ctrl.rd_we &&
                     i_w_ctrl.rd_sel == i_m_ctrl.rt_sel;
    assign o_store_data = w_store ? i_w_data : i_m_rt_data;

endmodule

`default_nettype wire

// ==== hdl/lc4_config.svh ====
//**************************************************
// sizes for the reduced lc4 core
// word and address share one width, pc wraps at 16 bits
//**************************************************
`ifndef LC4_CONFIG_SVH
`define LC4_CONFIG_SVH

// data and address width
`define LC4_WORD_W 16

// register file geometry
`define LC4_REG_SEL_W 3
`define LC4_NUM_REGS 8

// first fetch address after reset
`define LC4_RESET_PC 16'h8200

// trace stall code width
`define LC4_STALL_W 2

`endif

// ==== hdl/lc4_decoder.sv ====
//**************************************************
// combinational decode of the kept subset
// mul, div, shifts and immediate alu forms become nops
//**************************************************
`timescale 1ns/1ns
`default_nettype none
`include "lc4_config.svh"

module lc4_decoder (
    input  wire [`LC4_WORD_W-1:0] i_insn,
    output lc4_isa_pkg::ctrl_t    o_ctrl
);

    lc4_isa_pkg::opcode_t   opcode;
    lc4_isa_pkg::subop_t    subop;
    logic [`LC4_WORD_W-1:0] imm6;
    logic [`LC4_WORD_W-1:0] imm9;

    assign opcode = lc4_isa_pkg::opcode_t'(i_insn[15:12]);
    assign subop  = lc4_isa_pkg::subop_t'(i_insn[5:3]);
    // ldr/str offset and br/const immediate
    assign imm6   = {{(`LC4_WORD_W-6){i_insn[5]}}, i_insn[5:0]};
    assign imm9   = {{(`LC4_WORD_W-9){i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        o_ctrl        = '0;
        o_ctrl.rs_sel = i_insn[8:6];
        o_ctrl.rt_sel = i_insn[2:0];
        o_ctrl.rd_sel = i_insn[11:9];
        case (opcode)
            lc4_isa_pkg::op_br: begin
                // a zero mask is the nop, never a branch
                if (i_insn[11:9] != 3'b000) begin
                    o_ctrl.is_branch = 1'b1;
                    o_ctrl.br_mask   = i_insn[11:9];
                    o_ctrl.imm       = imm9;
                end
            end
            lc4_isa_pkg::op_add: begin
                if (subop == lc4_isa_pkg::fn_rr || subop == lc4_isa_pkg::fn_sub) begin
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt_re  = 1'b1;
                    o_ctrl.rd_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                    o_ctrl.alu_op = (subop == lc4_isa_pkg::fn_sub) ?
                                    lc4_isa_pkg::alu_sub : lc4_isa_pkg::alu_add;
                end
            end
            lc4_isa_pkg::op_and: begin
                if (subop == lc4_isa_pkg::fn_rr) begin
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt_re  = 1'b1;
                    o_ctrl.rd_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                    o_ctrl.alu_op = lc4_isa_pkg::alu_and;
                end
            end
            lc4_isa_pkg::op_ldr: begin
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rd_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
                o_ctrl.imm     = imm6;
            end
            lc4_isa_pkg::op_str: begin
                // store data register sits in the rd field
                o_ctrl.rt_sel   = i_insn[11:9];
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
                o_ctrl.imm      = imm6;
            end
            lc4_isa_pkg::op_const: begin
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
                o_ctrl.alu_op = lc4_isa_pkg::alu_pass;
                o_ctrl.imm    = imm9;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/lc4_hazard_unit.sv ====
//**************************************************
// load-use and load-to-branch stall, branch flush
// flush wins over stall in the same cycle
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module lc4_hazard_unit (
    input  wire lc4_isa_pkg::ctrl_t  i_d_ctrl,
    input  wire lc4_isa_pkg::ctrl_t  i_x_ctrl,
    input  wire                      i_x_branch_taken,
    output logic                     o_hold_fd,
    output logic                     o_flush_d,
    output logic                     o_bubble_x,
    output lc4_pipe_pkg::stall_t     o_x_stall
);

    logic rs_hit;
    logic rt_hit;
    logic load_stall;

    // store data is exempt, w to m bypass picks it up later
    assign rs_hit = i_d_ctrl.rs_re && i_d_ctrl.rs_sel == i_x_ctrl.rd_sel;
    assign rt_hit = i_d_ctrl.rt_re && !i_d_ctrl.is_store &&
                    i_d_ctrl.rt_sel == i_x_ctrl.rd_sel;

    // a branch waits for any load, the load sets nzp in m
    assign load_stall = i_x_ctrl.is_load && (rs_hit || rt_hit || i_d_ctrl.is_branch);

    assign o_flush_d  = i_x_branch_taken;
    assign o_hold_fd  = load_stall && !i_x_branch_taken;
    assign o_bubble_x = load_stall || i_x_branch_taken;
    assign o_x_stall  = i_x_branch_taken ? lc4_pipe_pkg::stall_branch :
                        lc4_pipe_pkg::stall_load;

endmodule

`default_nettype wire

// ==== hdl/lc4_isa_pkg.sv ====
//**************************************************
// lc4 subset: add/sub/and, const, ldr/str, br, nop
// every other encoding decodes as a nop
//**************************************************
`default_nettype none
`include "lc4_config.svh"

package lc4_isa_pkg;

    // major opcode, insn[15:12]
    typedef enum logic [3:0] {
        op_br    = 4'b0000,
        op_add   = 4'b0001,
        op_and   = 4'b0101,
        op_ldr   = 4'b0110,
        op_str   = 4'b0111,
        op_const = 4'b1001
    } opcode_t;

    // sub-opcode, insn[5:3]
    // fn_rr is add in the add group and and in the and group
    typedef enum logic [2:0] {
        fn_rr  = 3'b000,
        fn_sub = 3'b010
    } subop_t;

    typedef enum logic [1:0] {alu_add, alu_sub, alu_and, alu_pass} alu_op_t;

    // decoded control, all zero is a nop
    typedef struct packed {
        logic [`LC4_REG_SEL_W-1:0] rs_sel;
        logic [`LC4_REG_SEL_W-1:0] rt_sel;
        logic [`LC4_REG_SEL_W-1:0] rd_sel;
        logic                      rs_re;
        logic                      rt_re;
        logic                      rd_we;
        logic                      nzp_we;
        logic                      is_load;
        logic                      is_store;
        logic                      is_branch;
        logic [2:0]                br_mask;
        alu_op_t                   alu_op;
        logic [`LC4_WORD_W-1:0]    imm;
    } ctrl_t;

    // sign class of a word as n, z, p
    function automatic logic [2:0] nzp_of(input logic [`LC4_WORD_W-1:0] value);
        return (value == '0) ? 3'b010 : (value[`LC4_WORD_W-1] ? 3'b100 : 3'b001);
    endfunction

endpackage

`default_nettype wire

// ==== hdl/lc4_pipe_pkg.sv ====
//**************************************************
// pipeline records; stall code 1 is unused with one pipe
//**************************************************
`default_nettype none
`include "lc4_config.svh"

package lc4_pipe_pkg;

    // trace code carried with every slot
    typedef enum logic [`LC4_STALL_W-1:0] {
        stall_none   = 2'd0,
        stall_branch = 2'd2,
        stall_load   = 2'd3
    } stall_t;

    // one pipeline slot
    typedef struct packed {
        logic [`LC4_WORD_W-1:0] pc;
        logic [`LC4_WORD_W-1:0] insn;
        lc4_isa_pkg::ctrl_t     ctrl;
        stall_t                 stall;
    } stage_t;

    // empty slot tagged with why it is empty
    function automatic stage_t bubble(input stall_t code);
        stage_t slot;
        slot       = '0;
        slot.stall = code;
        return slot;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/lc4_processor.sv ====
//**************************************************
// single-issue 5-stage lc4 core, f d x m w
// memories must answer in the same cycle
//**************************************************
`timescale 1ns/1ns
`default_nettype none
`include "lc4_config.svh"

module lc4_processor (
    input  wire                      gwe,
    input  wire                      i_arst_n,
    output logic [`LC4_WORD_W-1:0]   o_cur_pc,
    input  wire [`LC4_WORD_W-1:0]    i_cur_insn,
    output logic [`LC4_WORD_W-1:0]   o_dmem_addr,
    input  wire [`LC4_WORD_W-1:0]    i_cur_dmem_data,
    output logic                     o_dmem_we,
    output logic [`LC4_WORD_W-1:0]   o_dmem_towrite,
    output lc4_pipe_pkg::stall_t     o_test_stall,
    output logic [`LC4_WORD_W-1:0]   o_test_cur_pc,
    output logic [`LC4_WORD_W-1:0]   o_test_cur_insn,
    output logic                     o_test_regfile_we,
    output logic [`LC4_REG_SEL_W-1:0] o_test_regfile_wsel,
    output logic [`LC4_WORD_W-1:0]   o_test_regfile_data,
    output logic                     o_test_nzp_we,
    output logic [2:0]               o_test_nzp_new_bits
);

    logic [`LC4_WORD_W-1:0] pc, d_pc, d_insn;
    lc4_pipe_pkg::stall_t   d_stall, hz_stall;
    lc4_isa_pkg::ctrl_t     d_ctrl;
    lc4_pipe_pkg::stage_t   x_q, m_q, w_q;
    logic [`LC4_WORD_W-1:0] rf_rs, rf_rt, x_rs_data, x_rt_data, rs_op, rt_op;
    logic [`LC4_WORD_W-1:0] alu_result, m_result, m_rt_data, store_data;
    logic [`LC4_WORD_W-1:0] w_result, w_load_data, w_data;
    logic [2:0]             alu_nzp, nzp_q;
    logic                   branch_taken, hold_fd, flush_d, bubble_x;

    lc4_decoder u_decoder (.i_insn(d_insn), .o_ctrl(d_ctrl));

    lc4_regfile u_regfile (
        .gwe(gwe), .i_arst_n(i_arst_n),
        .i_rs_sel(d_ctrl.rs_sel), .i_rt_sel(d_ctrl.rt_sel),
        .i_rd_sel(w_q.ctrl.rd_sel), .i_rd_we(w_q.ctrl.rd_we), .i_wdata(w_data),
        .o_rs_data(rf_rs), .o_rt_data(rf_rt)
    );

    lc4_hazard_unit u_hazard (
        .i_d_ctrl(d_ctrl), .i_x_ctrl(x_q.ctrl), .i_x_branch_taken(branch_taken),
        .o_hold_fd(hold_fd), .o_flush_d(flush_d), .o_bubble_x(bubble_x),
        .o_x_stall(hz_stall)
    );

    lc4_bypass_unit u_bypass (
        .i_x_ctrl(x_q.ctrl), .i_m_ctrl(m_q.ctrl), .i_w_ctrl(w_q.ctrl),
        .i_x_rs_data(x_rs_data), .i_x_rt_data(x_rt_data), .i_m_result(m_result),
        .i_m_rt_data(m_rt_data), .i_w_data(w_data),
        .o_rs_op(rs_op), .o_rt_op(rt_op), .o_store_data(store_data)
    );

    lc4_alu u_alu (
        .i_ctrl(x_q.ctrl), .i_pc(x_q.pc), .i_rs_data(rs_op), .i_rt_data(rt_op),
        .i_nzp(nzp_q), .o_result(alu_result), .o_nzp(alu_nzp),
        .o_branch_taken(branch_taken)
    );

    // f and d: redirect on a taken branch, hold on a load stall
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= `LC4_RESET_PC;
            d_pc    <= '0;
            d_insn  <= '0;
            d_stall <= lc4_pipe_pkg::stall_branch;
        end else if (flush_d) begin
            pc      <= alu_result;
            d_pc    <= '0;
            d_insn  <= '0;
            d_stall <= lc4_pipe_pkg::stall_branch;
        end else if (!hold_fd) begin
            pc      <= pc + 1'b1;
            d_pc    <= pc;
            d_insn  <= i_cur_insn;
            d_stall <= lc4_pipe_pkg::stall_none;
        end
    end

    // x, m, w slot records
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_q <= lc4_pipe_pkg::bubble(lc4_pipe_pkg::stall_branch);
            m_q <= lc4_pipe_pkg::bubble(lc4_pipe_pkg::stall_branch);
            w_q <= lc4_pipe_pkg::bubble(lc4_pipe_pkg::stall_branch);
        end else begin
            if (bubble_x) begin
                x_q <= lc4_pipe_pkg::bubble(hz_stall);
            end else begin
                x_q.pc    <= d_pc;
                x_q.insn  <= d_insn;
                x_q.ctrl  <= d_ctrl;
                x_q.stall <= d_stall;
            end
            m_q <= x_q;
            w_q <= m_q;
        end
    end

    // operand and result payload
    always_ff @(posedge gwe) begin
        x_rs_data   <= rf_rs;
        x_rt_data   <= rf_rt;
        m_result    <= alu_result;
        m_rt_data   <= rt_op;
        w_result    <= m_result;
        w_load_data <= i_cur_dmem_data;
    end

    // alu insns set nzp at end of x, loads at end of m
    // x is younger, so it wins when both write
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            nzp_q <= 3'b000;
        end else if (x_q.ctrl.nzp_we && !x_q.ctrl.is_load) begin
            nzp_q <= alu_nzp;
        end else if (m_q.ctrl.is_load) begin
            nzp_q <= lc4_isa_pkg::nzp_of(i_cur_dmem_data);
        end
    end

    assign o_cur_pc       = pc;
    assign o_dmem_addr    = m_result;
    assign o_dmem_we      = m_q.ctrl.is_store;
    assign o_dmem_towrite = store_data;

    // w write data and trace
    assign w_data              = w_q.ctrl.is_load ? w_load_data : w_result;
    assign o_test_stall        = w_q.stall;
    assign o_test_cur_pc       = w_q.pc;
    assign o_test_cur_insn     = w_q.insn;
    assign o_test_regfile_we   = w_q.ctrl.rd_we;
    assign o_test_regfile_wsel = w_q.ctrl.rd_sel;
    assign o_test_regfile_data = w_data;
    assign o_test_nzp_we       = w_q.ctrl.nzp_we;
    assign o_test_nzp_new_bits = lc4_isa_pkg::nzp_of(w_data);

    // a memory write only ever comes from a decoded str
    a_store_only: assert property (@(posedge gwe) disable iff (!i_arst_n)
        o_dmem_we |-> m_q.insn[15:12] == lc4_isa_pkg::op_str);

endmodule

`default_nettype wire

// ==== hdl/lc4_regfile.sv ====
//**************************************************
// 8 x 16 register file, 2 reads, 1 write
// reads see the value written in the same cycle
//**************************************************
`timescale 1ns/1ns
`default_nettype none
`include "lc4_config.svh"

module lc4_regfile (
    input  wire                      gwe,
    input  wire                      i_arst_n,
    input  wire [`LC4_REG_SEL_W-1:0] i_rs_sel,
    input  wire [`LC4_REG_SEL_W-1:0] i_rt_sel,
    input  wire [`LC4_REG_SEL_W-1:0] i_rd_sel,
    input  wire                      i_rd_we,
    input  wire [`LC4_WORD_W-1:0]    i_wdata,
    output logic [`LC4_WORD_W-1:0]   o_rs_data,
    output logic [`LC4_WORD_W-1:0]   o_rt_data
);

    logic [`LC4_WORD_W-1:0] regs [`LC4_NUM_REGS];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `LC4_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_wdata;
        end
    end

    // write-through covers the w to d distance
    assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

    // w stage must never retire a write to an unknown register
    a_wsel_known: assert property (@(posedge gwe) disable iff (!i_arst_n)
        i_rd_we |-> !$isunknown(i_rd_sel));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the lc4 testbench with verilator, pass only on the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_lc4_processor --Mdir obj_dir -o tb_lc4_processor \
    && ./obj_dir/tb_lc4_processor | tee sim.log \
    && grep -q "^Result: PASSED$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== verification/tb_lc4_program.svh ====
//**************************************************
// program at LC4_RESET_PC, expected w-stage retirements, store and data tables
// retirement columns: behavior, stall, pc, regfile we, wsel, data, nzp
//**************************************************
`ifndef TB_LC4_PROGRAM_SVH
`define TB_LC4_PROGRAM_SVH

// one counted w-stage slot
typedef struct packed {
    logic [2:0]           beh;
    lc4_pipe_pkg::stall_t stall;
    logic [15:0]          pc;
    logic                 we;
    logic [2:0]           wsel;
    logic [15:0]          data;
    logic [2:0]           nzp;
} retire_t;

localparam int PROG_LEN = 24;

// 0-5 const/add chain, 6-11 stores and loads, 12-15 brz over two consts
// 16-19 brp not taken and a load, 20-22 load then brp over one const
localparam logic [15:0] PROG [PROG_LEN] = '{
    16'h9205, 16'h95fd, 16'h1642, 16'h18c3, 16'h1b11, 16'h5d42,
    16'h9010, 16'h7c02, 16'h6e02, 16'h13c1, 16'h6405, 16'h7406,
    16'h9600, 16'h0402, 16'h9807, 16'h9809, 16'h99ff, 16'h0201,
    16'h1b04, 16'h6c06, 16'h0201, 16'h9e01, 16'h5f84, 16'h0000
};

localparam int EXP_LEN = 23;

localparam retire_t EXP [EXP_LEN] = '{
    '{3'd1, lc4_pipe_pkg::stall_none,   16'h8200, 1'b1, 3'd1, 16'h0005, 3'b001},
    '{3'd1, lc4_pipe_pkg::stall_none,   16'h8201, 1'b1, 3'd2, 16'hfffd, 3'b100},
    '{3'd2, lc4_pipe_pkg::stall_none,   16'h8202, 1'b1, 3'd3, 16'h0002, 3'b001},
    '{3'd2, lc4_pipe_pkg::stall_none,   16'h8203, 1'b1, 3'd4, 16'h0004, 3'b001},
    '{3'd2, lc4_pipe_pkg::stall_none,   16'h8204, 1'b1, 3'd5, 16'hffff, 3'b100},
    '{3'd1, lc4_pipe_pkg::stall_none,   16'h8205, 1'b1, 3'd6, 16'hfffd, 3'b100},
    '{3'd1, lc4_pipe_pkg::stall_none,   16'h8206, 1'b1, 3'd0, 16'h0010, 3'b001},
    '{3'd4, lc4_pipe_pkg::stall_none,   16'h8207, 1'b0, 3'd0, 16'h0000, 3'b000},
    '{3'd3, lc4_pipe_pkg::stall_none,   16'h8208, 1'b1, 3'd7, 16'hfffd, 3'b100},
    '{3'd3, lc4_pipe_pkg::stall_load,   16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000},
    '{3'd3, lc4_pipe_pkg::stall_none,   16'h8209, 1'b1, 3'd1, 16'h0002, 3'b001},
    '{3'd3, lc4_pipe_pkg::stall_none,   16'h820a, 1'b1, 3'd2, 16'h1234, 3'b001},
    '{3'd4, lc4_pipe_pkg::stall_none,   16'h820b, 1'b0, 3'd0, 16'h0000, 3'b000},
    '{3'd1, lc4_pipe_pkg::stall_none,   16'h820c, 1'b1, 3'd3, 16'h0000, 3'b010},
    '{3'd5, lc4_pipe_pkg::stall_branch, 16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000},
    '{3'd5, lc4_pipe_pkg::stall_branch, 16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000},
    '{3'd1, lc4_pipe_pkg::stall_none,   16'h8210, 1'b1, 3'd4, 16'hffff, 3'b100},
    '{3'd2, lc4_pipe_pkg::stall_none,   16'h8212, 1'b1, 3'd5, 16'hfffe, 3'b100},
    '{3'd3, lc4_pipe_pkg::stall_none,   16'h8213, 1'b1, 3'd6, 16'h1234, 3'b001},
    '{3'd3, lc4_pipe_pkg::stall_load,   16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000},
    '{3'd5, lc4_pipe_pkg::stall_branch, 16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000},
    '{3'd5, lc4_pipe_pkg::stall_branch, 16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000},
    '{3'd1, lc4_pipe_pkg::stall_none,   16'h8216, 1'b1, 3'd7, 16'h1234, 3'b001}
};

// stores seen in m, as address and data
localparam int STORE_LEN = 2;
localparam logic [31:0] STORES [STORE_LEN] = '{{16'h0012, 16'hfffd}, {16'h0016, 16'h1234}};

// data memory words set before the run, as address and value
localparam int DMEM_LEN = 1;
localparam logic [31:0] DMEM_INIT [DMEM_LEN] = '{{16'h0015, 16'h1234}};

`endif

// ==== verification/tb_lc4_processor.sv ====
//**************************************************
// lc4 core testbench, memories answer in the same cycle
// data memory is 64 words, indexed by the low address bits
//**************************************************
`timescale 1ns/1ns
`default_nettype none
`include "lc4_config.svh"

module tb_lc4_processor;

    `include "tb_lc4_program.svh"

    localparam int TIMEOUT_CYCLES = PROG_LEN * 4 + 20;

    logic                 gwe;
    logic                 i_arst_n;
    logic [15:0]          i_cur_insn;
    logic [15:0]          i_cur_dmem_data;
    wire  [15:0]          o_cur_pc;
    wire  [15:0]          o_dmem_addr;
    wire                  o_dmem_we;
    wire  [15:0]          o_dmem_towrite;
    lc4_pipe_pkg::stall_t o_test_stall;
    wire  [15:0]          o_test_cur_pc;
    wire  [15:0]          o_test_cur_insn;
    wire                  o_test_regfile_we;
    wire  [2:0]           o_test_regfile_wsel;
    wire  [15:0]          o_test_regfile_data;
    wire                  o_test_nzp_we;
    wire  [2:0]           o_test_nzp_new_bits;

    logic [15:0] dmem [64];
    int          cycles = 0;
    int          ret_idx = 0;
    int          store_idx = 0;
    int          tail = 0;
    int          checks = 0;
    int          misc_errs = 0;
    int          total_errs = 0;
    int          errs [1:6] = '{default: 0};
    logic        started = 1'b0;
    logic        done = 1'b0;
    logic        timed_out = 1'b0;
    string       beh_name [1:6] = '{"alu and const results", "m and w operand bypass",
                                    "load-use stall", "store address and data",
                                    "branch flush", "nzp trace bits"};

    lc4_processor u_dut (
        .gwe(gwe), .i_arst_n(i_arst_n),
        .o_cur_pc(o_cur_pc), .i_cur_insn(i_cur_insn),
        .o_dmem_addr(o_dmem_addr), .i_cur_dmem_data(i_cur_dmem_data),
        .o_dmem_we(o_dmem_we), .o_dmem_towrite(o_dmem_towrite),
        .o_test_stall(o_test_stall), .o_test_cur_pc(o_test_cur_pc),
        .o_test_cur_insn(o_test_cur_insn), .o_test_regfile_we(o_test_regfile_we),
        .o_test_regfile_wsel(o_test_regfile_wsel),
        .o_test_regfile_data(o_test_regfile_data),
        .o_test_nzp_we(o_test_nzp_we), .o_test_nzp_new_bits(o_test_nzp_new_bits)
    );

    // 20 ns period
    initial gwe = 1'b0;
    always #10 gwe = ~gwe;

    task automatic compare_value(input int beh, input logic [31:0] got,
                                 input logic [31:0] want, input string what);
        checks++;
        if (got !== want) begin
            $display("error %0t ns: behavior %0d, %s is %h, expected %h",
                     $time, beh, what, got, want);
            errs[beh]++;
        end
    endtask

    // instruction fetch, store write, then load data for the slot in m
    task automatic drive_memories();
        logic [15:0] offset;
        offset = o_cur_pc - `LC4_RESET_PC;
        if (o_dmem_we) begin
            dmem[o_dmem_addr[5:0]] = o_dmem_towrite;
        end
        if (offset < 16'(PROG_LEN)) begin
            i_cur_insn = PROG[offset[4:0]];
        end else begin
            i_cur_insn = 16'h0000;
        end
        i_cur_dmem_data = dmem[o_dmem_addr[5:0]];
    endtask

    // register writes, stores and bubbles count as retirements
    task automatic watch_retire();
        logic        store_w;
        logic        counted;
        logic [15:0] insn_off;
        logic [15:0] want_insn;
        retire_t     row;
        store_w = o_test_stall == lc4_pipe_pkg::stall_none &&
                  o_test_cur_insn[15:12] == 4'b0111;
        counted = o_test_regfile_we || store_w || o_test_stall != lc4_pipe_pkg::stall_none;
        // reset bubbles come before the first instruction
        if (counted && (started || o_test_stall == lc4_pipe_pkg::stall_none)) begin
            started = 1'b1;
            if (ret_idx >= EXP_LEN) begin
                $display("unexpected retirement at pc %h after the last expected one",
                         o_test_cur_pc);
                misc_errs++;
            end else begin
                row = EXP[ret_idx];
                // bubbles carry a zero word, real slots the word fetched at their pc
                insn_off  = row.pc - `LC4_RESET_PC;
                want_insn = (row.stall == lc4_pipe_pkg::stall_none) ?
                            PROG[insn_off[4:0]] : 16'h0000;
                compare_value(row.beh, o_test_stall, row.stall, "stall code");
                compare_value(row.beh, o_test_cur_pc, row.pc, "retired pc");
                compare_value(row.beh, o_test_cur_insn, want_insn, "retired insn");
                compare_value(row.beh, o_test_regfile_we, row.we, "regfile we");
                // every register writer in the subset also sets nzp
                compare_value(6, o_test_nzp_we, row.we, "nzp we");
                if (row.we) begin
                    compare_value(row.beh, o_test_regfile_wsel, row.wsel, "regfile wsel");
                    compare_value(row.beh, o_test_regfile_data, row.data, "regfile data");
                    compare_value(6, o_test_nzp_new_bits, row.nzp, "nzp bits");
                end
                ret_idx++;
            end
        end
    endtask

    // stores are checked in m, where address and data leave the core
    task automatic watch_store();
        if (o_dmem_we) begin
            if (store_idx >= STORE_LEN) begin
                $display("unexpected store to address %h", o_dmem_addr);
                misc_errs++;
            end else begin
                compare_value(4, o_dmem_addr, STORES[store_idx][31:16], "store address");
                compare_value(4, o_dmem_towrite, STORES[store_idx][15:0], "store data");
                store_idx++;
            end
        end
    endtask

    initial begin
        i_arst_n        = 1'b0;
        i_cur_insn      = 16'h0000;
        i_cur_dmem_data = 16'h0000;
        // fill from the full index, then the preloaded words
        for (int a = 0; a < 64; a++) begin
            dmem[a] = 16'(a * 37) ^ 16'ha500;
        end
        for (int i = 0; i < DMEM_LEN; i++) begin
            dmem[DMEM_INIT[i][21:16]] = DMEM_INIT[i][15:0];
        end
        repeat (3) @(posedge gwe);
        @(negedge gwe);
        i_arst_n = 1'b1;
        drive_memories();
        // outputs settle after the rising edge, so sample and drive here
        while (!done && !timed_out) begin
            @(negedge gwe);
            cycles++;
            watch_retire();
            watch_store();
            drive_memories();
            if (ret_idx >= EXP_LEN) begin
                tail++;
            end
            // a few idle cycles catch anything retiring late
            if (tail >= 6) begin
                done = 1'b1;
            end
            if (cycles >= TIMEOUT_CYCLES) begin
                timed_out = 1'b1;
                $display("timeout: expected retirements still missing after %0d cycles",
                         TIMEOUT_CYCLES);
            end
        end
        compare_value(5, ret_idx, EXP_LEN, "retirement count");
        compare_value(4, store_idx, STORE_LEN, "store count");
        for (int b = 1; b <= 6; b++) begin
            $display("behavior %0d, %s: %s", b, beh_name[b], (errs[b] == 0) ? "ok" : "mismatch");
            total_errs += errs[b];
        end
        $display("checks %0d, errors %0d, other failures %0d", checks, total_errs, misc_errs);
        if (!timed_out && total_errs == 0 && misc_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
